// ==== verification/soc_fabric_trace.txt ====
# columns: op addr wdata strb value, all hex; op is write, read or poll
# for a write value is the led port afterwards, for read and poll it is the read data
read  20000000 00000000 0 00000000
read  10000004 00000000 0 00000010
write 00000010 11223344 f 00000000
write 00000010 aabbccdd 5 00000000
write 00000014 cafef00d f 00000000
write 00000014 00990000 4 00000000
write 00000ffc 01020304 f 00000000
write 00000ffc a5a5a5a5 a 00000000
read  00000010 00000000 0 11bb33dd
read  00000014 00000000 0 ca99f00d
read  00000ffc 00000000 0 a502a504
write 20000000 0000003a 1 0000003a
write 20000000 000000ff 2 0000003a
read  20000000 00000000 0 0000003a
write 20000000 12345615 f 00000015
read  20000000 00000000 0 00000015
write 10000004 5a5a0107 3 00000015
read  10000004 00000000 0 00000107
write 10000004 00000017 2 00000015
read  10000004 00000000 0 00000007
write 10000004 ffffff0b 1 00000015
read  10000004 00000000 0 0000000b
read  30000000 00000000 0 deadbeef
read  f0000010 00000000 0 deadbeef
write 30000000 00000000 f 00000015
write 40000010 00000000 f 00000015
write f0000004 ffffffff f 00000015
read  00000010 00000000 0 11bb33dd
read  20000000 00000000 0 00000015
read  10000004 00000000 0 0000000b
read  10000000 00000000 0 ffffffff
write 10000000 00000055 1 00000015
write 10000000 000000a3 1 00000015
poll  10000000 00000000 0 00000055
read  10000000 00000000 0 ffffffff
poll  10000000 00000000 0 000000a3
read  10000000 00000000 0 ffffffff

// ==== sim.f ====
verilog/soc_pkg.sv
verilog/bus_ram.sv
verilog/bus_uart.sv
verilog/bus_decode.sv
verilog/soc_fabric.sv
verification/soc_fabric_tb.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - files:
      - verilog/soc_pkg.sv
      - verilog/bus_ram.sv
      - verilog/bus_uart.sv
      - verilog/bus_decode.sv
      - verilog/soc_fabric.sv
  - target: test
    files:
      - verification/soc_fabric_tb.sv

// ==== verification/soc_fabric_tb.sv ====
// testbench for the peripheral fabric; replays the bus trace and decodes UART frames on the loopback
`timescale 1ns/1ps

module soc_fabric_tb;

	localparam int clk_period = 100;
	localparam int sample_delay = 40; // outputs are read 10 ns before the rising edge
	localparam int mem_words = 1024;
	localparam logic [31:0] div_reset = 16;
	localparam int frame_bits = 10;

	logic clk;
	logic reset;
	logic mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0] mem_wstrb;
	logic mem_ready;
	logic [31:0] mem_rdata;
	logic [5:0] led;
	logic uart_tx;

	string trace_op [$];
	logic [31:0] trace_addr [$];
	logic [31:0] trace_wdata [$];
	logic [3:0] trace_strb [$];
	logic [31:0] trace_value [$];
	bit trace_loaded = 0;
	longint watchdog_cycles;

	int cycle = 0;
	logic [31:0] div_model = div_reset;
	int tx_free = 0; // sample count at which the transmitter is idle again
	logic [7:0] tx_bytes [$];

	soc_fabric #(
		.mem_words(mem_words),
		.div_reset(div_reset)
	) soc_fabric_inst (
		.clk(clk),
		.reset(reset),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.led(led),
		.uart_tx(uart_tx),
		.uart_rx(uart_tx) // loopback
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		stop_run($sformatf("Mismatch at time %0t: %s", $time, msg));
	endtask

	task automatic wait_sample_point();
		@(negedge clk);
		#(sample_delay);
	endtask

	function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
			input logic [3:0] strb);
		logic [31:0] result;
		result = old;
		for (int lane = 0; lane < 4; lane++) begin
			if (strb[lane]) result[lane*8 +: 8] = wdata[lane*8 +: 8];
		end
		return result;
	endfunction

	function automatic bit is_div_addr(input logic [31:0] addr);
		return addr[31:28] == 4'h1 && addr[2];
	endfunction

	function automatic bit is_dat_addr(input logic [31:0] addr);
		return addr[31:28] == 4'h1 && !addr[2];
	endfunction

	// RAM answers one cycle late, a UART data write waits for the transmitter, all else at once
	function automatic int expected_done(input logic [31:0] addr, input logic [3:0] strb,
			input int first);
		if (addr[31:28] == 4'h0) return first + 1;
		if (is_dat_addr(addr) && strb[0]) return (tx_free > first) ? tx_free : first;
		return first;
	endfunction

	task automatic load_trace();
		int fd;
		int code;
		string op;
		string rest;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] strb;
		logic [31:0] value;
		fd = $fopen("verification/soc_fabric_trace.txt", "r");
		if (fd == 0) begin
			stop_run("cannot open the trace file verification/soc_fabric_trace.txt");
		end else begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op == "#") begin
					code = $fgets(rest, fd); // comment line
				end else begin
					code = $fscanf(fd, "%h %h %h %h", addr, wdata, strb, value);
					if (code != 4) stop_run($sformatf("trace line for %s is incomplete", op));
					trace_op.push_back(op);
					trace_addr.push_back(addr);
					trace_wdata.push_back(wdata);
					trace_strb.push_back(strb[3:0]);
					trace_value.push_back(value);
				end
			end
			$fclose(fd);
		end
	endtask

	// trace length times the longest frame that any divider in the trace gives, twice over
	function automatic longint watchdog_limit();
		logic [31:0] div;
		logic [31:0] max_div;
		div = div_reset;
		max_div = div;
		foreach (trace_op[i]) begin
			if (trace_op[i] == "write" && is_div_addr(trace_addr[i])) begin
				div = merge_lanes(div, trace_wdata[i], trace_strb[i]);
				if (div > max_div) max_div = div;
			end
		end
		return longint'(trace_op.size()) * frame_bits * (longint'(max_div) + 1) * 2;
	endfunction

	task automatic bus_transfer(input int i, output logic [31:0] rdata);
		int first;
		int want;
		@(negedge clk);
		mem_valid = 1'b1;
		mem_addr = trace_addr[i];
		mem_wdata = trace_wdata[i];
		mem_wstrb = trace_strb[i];
		#(sample_delay);
		first = cycle;
		while (mem_ready !== 1'b1) begin
			wait_sample_point();
		end
		rdata = mem_rdata;
		want = expected_done(trace_addr[i], trace_strb[i], first);
		assert (cycle == want) else report_mismatch($sformatf(
			"%s %h: ready after %0d cycles, not %0d",
			trace_op[i], trace_addr[i], cycle - first, want - first));
		if (trace_op[i] == "write" && is_dat_addr(trace_addr[i]) && trace_strb[i][0]) begin
			tx_bytes.push_back(trace_wdata[i][7:0]);
			tx_free = cycle + 1 + frame_bits * (div_model + 1);
		end
		@(negedge clk);
		mem_valid = 1'b0;
	endtask

	task automatic run_op(input int i);
		logic [31:0] rdata;
		if (trace_op[i] == "write") begin
			bus_transfer(i, rdata);
			if (is_div_addr(trace_addr[i])) begin
				div_model = merge_lanes(div_model, trace_wdata[i], trace_strb[i]);
			end
			assert (led === trace_value[i][5:0]) else report_mismatch($sformatf(
				"led is %h after write to %h, expected %h", led, trace_addr[i], trace_value[i][5:0]));
		end else if (trace_op[i] == "read" || trace_op[i] == "poll") begin
			bus_transfer(i, rdata);
			while (trace_op[i] == "poll" && rdata === 32'hffff_ffff) begin
				bus_transfer(i, rdata); // nothing received yet
			end
			assert (rdata === trace_value[i]) else report_mismatch($sformatf(
				"%s %h returned %h, expected %h", trace_op[i], trace_addr[i], rdata, trace_value[i]));
		end else begin
			stop_run($sformatf("unknown trace opcode %s", trace_op[i]));
		end
	endtask

	// each bit must hold its level for exactly div+1 samples
	task automatic decode_frame();
		int bit_len;
		int ones;
		logic [9:0] frame;
		bit_len = div_model + 1;
		for (int b = 0; b < frame_bits; b++) begin
			ones = 0;
			for (int s = 0; s < bit_len; s++) begin
				if (b != 0 || s != 0) wait_sample_point();
				if (uart_tx === 1'b1) ones++;
			end
			assert (ones == 0 || ones == bit_len) else report_mismatch($sformatf(
				"uart_tx bit %0d is not steady for %0d cycles", b, bit_len));
			frame[b] = (ones != 0);
		end
		assert (frame[9] == 1'b1) else report_mismatch("stop bit is low");
		assert (tx_bytes.size() > 0) else stop_run("the UART sent a frame that no write asked for");
		assert (frame[8:1] == tx_bytes[0]) else report_mismatch($sformatf(
			"uart_tx sent %h, expected %h", frame[8:1], tx_bytes[0]));
		void'(tx_bytes.pop_front());
	endtask

	initial begin
		@(negedge reset);
		forever begin
			wait_sample_point();
			if (uart_tx === 1'b0) decode_frame();
		end
	end

	initial begin
		@(negedge reset);
		forever begin
			wait_sample_point();
			if (mem_valid === 1'b0) begin
				assert (mem_ready === 1'b0)
					else report_mismatch("mem_ready high while mem_valid is low");
			end
		end
	end

	initial begin
		wait (trace_loaded);
		repeat (watchdog_cycles) @(posedge clk);
		stop_run($sformatf("watchdog expired after %0d cycles before the trace finished",
			watchdog_cycles));
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		load_trace();
		watchdog_cycles = watchdog_limit();
		trace_loaded = 1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#(sample_delay);
		assert (led === 6'd0 && uart_tx === 1'b1 && mem_ready === 1'b0)
			else report_mismatch("outputs not idle after reset");
		foreach (trace_op[i]) run_op(i);
		while (tx_bytes.size() != 0) wait_sample_point(); // last frames still on the line
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== verilog/soc_fabric.sv ====
// peripheral fabric top; joins decoder, RAM and UART behind one valid/ready memory bus
`timescale 1ns/1ps

module soc_fabric #(
	parameter int mem_words = 1024,
	parameter logic [soc_pkg::data_width-1:0] div_reset = 16
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             mem_valid,
	input  logic [soc_pkg::addr_width-1:0]   mem_addr,
	input  logic [soc_pkg::data_width-1:0]   mem_wdata,
	input  logic [soc_pkg::strb_width-1:0]   mem_wstrb,
	output logic                             mem_ready,
	output logic [soc_pkg::data_width-1:0]   mem_rdata,
	output logic [5:0]                       led,
	output logic                             uart_tx,
	input  logic                             uart_rx
);

	import soc_pkg::*;

	localparam int ram_addr_bits = $clog2(mem_words); // word index above the byte offset

	logic ram_sel;
	logic [strb_width-1:0] ram_wen;
	logic [data_width-1:0] ram_rdata;
	logic ram_ready;
	logic [strb_width-1:0] div_we;
	logic dat_we;
	logic dat_re;
	logic [data_width-1:0] div_rdata;
	logic [data_width-1:0] dat_rdata;
	logic dat_wait;

	bus_decode bus_decode_inst (
		.clk(clk),
		.reset(reset),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.ram_sel(ram_sel),
		.ram_wen(ram_wen),
		.ram_rdata(ram_rdata),
		.ram_ready(ram_ready),
		.div_we(div_we),
		.dat_we(dat_we),
		.dat_re(dat_re),
		.div_rdata(div_rdata),
		.dat_rdata(dat_rdata),
		.dat_wait(dat_wait),
		.led(led)
	);

	bus_ram #(.mem_words(mem_words)) bus_ram_inst (
		.clk(clk),
		.ram_sel(ram_sel),
		.ram_wen(ram_wen),
		.mem_addr(mem_addr[ram_addr_bits+1:2]),
		.mem_wdata(mem_wdata),
		.ram_rdata(ram_rdata),
		.ram_ready(ram_ready)
	);

	bus_uart #(.div_reset(div_reset)) bus_uart_inst (
		.clk(clk),
		.reset(reset),
		.div_we(div_we),
		.mem_wdata(mem_wdata),
		.dat_we(dat_we),
		.dat_re(dat_re),
		.div_rdata(div_rdata),
		.dat_rdata(dat_rdata),
		.dat_wait(dat_wait),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx)
	);

endmodule

// ==== verilog/bus_decode.sv ====
// address decoder for the fabric; steers the bus to RAM and UART, owns the LED register
`timescale 1ns/1ps

module bus_decode (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             mem_valid,
	input  logic [soc_pkg::addr_width-1:0]   mem_addr,
	input  logic [soc_pkg::data_width-1:0]   mem_wdata,
	input  logic [soc_pkg::strb_width-1:0]   mem_wstrb,
	output logic                             mem_ready,
	output logic [soc_pkg::data_width-1:0]   mem_rdata,
	output logic                             ram_sel,
	output logic [soc_pkg::strb_width-1:0]   ram_wen,
	input  logic [soc_pkg::data_width-1:0]   ram_rdata,
	input  logic                             ram_ready,
	output logic [soc_pkg::strb_width-1:0]   div_we,
	output logic                             dat_we,
	output logic                             dat_re,
	input  logic [soc_pkg::data_width-1:0]   div_rdata,
	input  logic [soc_pkg::data_width-1:0]   dat_rdata,
	input  logic                             dat_wait,
	output logic [5:0]                       led
);

	import soc_pkg::*;

	region_t region;
	logic div_sel;
	logic dat_sel;
	logic led_sel;
	logic none_sel;

	always_comb begin
		case (mem_addr[addr_width-1 -: 4])
			4'h0: region = region_ram;
			4'h1: region = region_uart;
			4'h2: region = region_led;
			default: region = region_none;
		endcase
	end

	assign ram_sel = mem_valid && (region == region_ram);
	assign dat_sel = mem_valid && (region == region_uart) && !mem_addr[2];
	assign div_sel = mem_valid && (region == region_uart) && mem_addr[2];
	assign led_sel = mem_valid && (region == region_led);
	assign none_sel = mem_valid && (region == region_none);

	// the RAM write lands once, before ready comes back
	assign ram_wen = (ram_sel && !ram_ready) ? mem_wstrb : '0;

	assign div_we = div_sel ? mem_wstrb : '0;
	assign dat_we = dat_sel && mem_wstrb[0];
	assign dat_re = dat_sel && (mem_wstrb == '0); // a read has no strobes

	always_ff @(posedge clk) begin
		if (reset) begin
			led <= '0;
		end else if (led_sel && mem_wstrb[0]) begin
			led <= mem_wdata[5:0];
		end
	end

	// everything but RAM and a stalled UART write answers in the same cycle
	assign mem_ready = ram_ready || div_sel || led_sel || none_sel || (dat_sel && !dat_wait);

	always_comb begin
		case (region)
			region_ram: mem_rdata = ram_rdata;
			region_uart: mem_rdata = mem_addr[2] ? div_rdata : dat_rdata;
			region_led: mem_rdata = {{(data_width-6){1'b0}}, led};
			default: mem_rdata = unmapped_rdata;
		endcase
	end

endmodule

// ==== verilog/bus_uart.sv ====
// UART peripheral with a divider register, 8N1 transmitter and one-byte receive buffer
`timescale 1ns/1ps

module bus_uart #(
	parameter logic [soc_pkg::data_width-1:0] div_reset = 16
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [soc_pkg::strb_width-1:0]   div_we,
	input  logic [soc_pkg::data_width-1:0]   mem_wdata,
	input  logic                             dat_we,
	input  logic                             dat_re,
	output logic [soc_pkg::data_width-1:0]   div_rdata,
	output logic [soc_pkg::data_width-1:0]   dat_rdata,
	output logic                             dat_wait,
	output logic                             uart_tx,
	input  logic                             uart_rx
);

	import soc_pkg::*;

	logic [data_width-1:0] div; // bit time is div+1 clock cycles

	uart_state_t tx_state;
	logic [data_width-1:0] tx_cnt;
	logic [2:0] tx_bit;
	logic [uart_bits-1:0] tx_shift;

	uart_state_t rx_state;
	logic [data_width-1:0] rx_cnt;
	logic [2:0] rx_bit;
	logic [uart_bits-1:0] rx_shift;
	logic [1:0] rx_sync;
	logic [uart_bits-1:0] rx_byte;
	logic rx_full;

	always_ff @(posedge clk) begin
		if (reset) begin
			div <= div_reset;
		end else begin
			for (int lane = 0; lane < strb_width; lane++) begin
				if (div_we[lane]) begin
					div[lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
				end
			end
		end
	end

	assign div_rdata = div;

	// a write is only taken while the transmitter sits idle
	assign dat_wait = dat_we && (tx_state != uart_idle);

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_state <= uart_idle;
			tx_cnt <= '0;
			tx_bit <= '0;
			uart_tx <= 1'b1;
		end else begin
			case (tx_state)
				uart_idle: begin
					if (dat_we) begin
						tx_shift <= mem_wdata[uart_bits-1:0];
						tx_cnt <= div;
						uart_tx <= 1'b0; // start bit begins next cycle
						tx_state <= uart_start;
					end
				end
				uart_start: begin
					if (tx_cnt == 0) begin
						uart_tx <= tx_shift[0]; // lsb goes out first
						tx_shift <= tx_shift >> 1;
						tx_bit <= '0;
						tx_cnt <= div;
						tx_state <= uart_data;
					end else begin
						tx_cnt <= tx_cnt - 1'b1;
					end
				end
				uart_data: begin
					if (tx_cnt == 0) begin
						tx_cnt <= div;
						if (tx_bit == 3'd7) begin
							uart_tx <= 1'b1;
							tx_state <= uart_stop;
						end else begin
							uart_tx <= tx_shift[0];
							tx_shift <= tx_shift >> 1;
							tx_bit <= tx_bit + 1'b1;
						end
					end else begin
						tx_cnt <= tx_cnt - 1'b1;
					end
				end
				uart_stop: begin
					if (tx_cnt == 0) begin
						tx_state <= uart_idle;
					end else begin
						tx_cnt <= tx_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	// two flops bring the pin into the clock domain
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_state <= uart_idle;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_full <= 1'b0;
		end else begin
			if (dat_re) begin
				rx_full <= 1'b0;
			end
			case (rx_state)
				uart_idle: begin
					if (!rx_sync[1]) begin
						rx_cnt <= div >> 1; // half a bit lands on the middle
						rx_state <= uart_start;
					end
				end
				uart_start: begin
					if (rx_cnt == 0) begin
						rx_cnt <= div;
						rx_bit <= '0;
						// a high line here was only a glitch
						rx_state <= rx_sync[1] ? uart_idle : uart_data;
					end else begin
						rx_cnt <= rx_cnt - 1'b1;
					end
				end
				uart_data: begin
					if (rx_cnt == 0) begin
						rx_shift <= {rx_sync[1], rx_shift[uart_bits-1:1]};
						rx_cnt <= div;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7) begin
							rx_state <= uart_stop;
						end
					end else begin
						rx_cnt <= rx_cnt - 1'b1;
					end
				end
				uart_stop: begin
					if (rx_cnt == 0) begin
						if (rx_sync[1]) begin
							rx_byte <= rx_shift; // overwrites an unread byte
							rx_full <= 1'b1;
						end
						rx_state <= uart_idle;
					end else begin
						rx_cnt <= rx_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	assign dat_rdata = rx_full ? {{(data_width-uart_bits){1'b0}}, rx_byte} : uart_empty_rdata;

endmodule

// ==== verilog/bus_ram.sv ====
// word RAM on the memory bus; byte-lane writes, registered read, ready one cycle after select
`timescale 1ns/1ps

module bus_ram #(
	parameter int mem_words = 1024
) (
	input  logic                             clk,
	input  logic                             ram_sel,
	input  logic [soc_pkg::strb_width-1:0]   ram_wen,
	input  logic [$clog2(mem_words)-1:0]     mem_addr,
	input  logic [soc_pkg::data_width-1:0]   mem_wdata,
	output logic [soc_pkg::data_width-1:0]   ram_rdata,
	output logic                             ram_ready
);

	import soc_pkg::*;

	logic [data_width-1:0] mem [mem_words];

	// each strobe writes its own byte lane
	always_ff @(posedge clk) begin
		for (int lane = 0; lane < strb_width; lane++) begin
			if (ram_wen[lane]) begin
				mem[mem_addr][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
			end
		end
	end

	// read sees the old word when a write hits the same address in that cycle
	always_ff @(posedge clk) begin
		if (ram_sel) begin
			ram_rdata <= mem[mem_addr];
		end
	end

	// a held select would otherwise retrigger ready on the following cycle
	always_ff @(posedge clk) begin
		ram_ready <= ram_sel && !ram_ready;
	end

endmodule

// ==== verilog/soc_pkg.sv ====
// shared bus widths, region and UART state encodings; imported by every fabric module
package soc_pkg;

	localparam int addr_width = 32; // byte address on the memory bus
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8; // one write strobe per byte lane

	// address bits 31..28 pick the region
	typedef enum logic [3:0] {
		region_ram  = 4'd0,
		region_uart = 4'd1,
		region_led  = 4'd2,
		region_none = 4'd15 // stands for every code without a unit behind it
	} region_t;

	// one encoding serves both the transmit and the receive machine
	typedef enum logic [1:0] {
		uart_idle,
		uart_start,
		uart_data,
		uart_stop
	} uart_state_t;

	// read data for addresses that map to nothing
	localparam logic [data_width-1:0] unmapped_rdata = 32'hDEADBEEF;

	// a data read with an empty receive buffer returns this
	localparam logic [data_width-1:0] uart_empty_rdata = '1;

	// UART frames carry one byte
	localparam int uart_bits = 8;

endpackage
